// File: saturnBusGlue.f
+incdir+include
src/saturnBusPkg.sv
src/saturnTimingPkg.sv
src/saturnIfs.sv
src/clockEnableGen.sv
src/busReadRouter.sv
src/busActivityMonitor.sv
src/saturnBusGlue.sv
verification/tbClockGen.sv
verification/saturnBusGlue_props.sv
verification/saturnBusGlueTb.sv

// File: Makefile
# Verilator simulation of saturnBusGlue

VERILATOR ?= verilator
TOP ?= saturnBusGlueTb
FILELIST ?= saturnBusGlue.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
PASS_MSG ?= Testbench passed

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_MSG"

$(SIM): $(FILELIST) $(shell grep -v '^+' $(FILELIST)) include/saturn_config.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/saturnBusGlueTb.sv
`timescale 1ns/10ps
`default_nettype none

`include "saturn_config.svh"

module saturnBusGlueTb import saturnBusPkg::*, saturnTimingPkg::*; ();

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 8;
	localparam int NUM_CYCLES = 4000;
	localparam int TIMEOUT_NS = (NUM_CYCLES + RESET_CYCLES) * CLK_PERIOD * 2;
	localparam smpcDivCnt_t DivLast = smpcDivCnt_t'(`SMPC_DIV - 1);
	localparam cpuAddr_t HookAddr = `BOOT_HOOK_ADDR;

	logic CLK, RST_N, ce, dbgPause;
	cpuAddr_t cpuA;
	cpuData_t cpuDo, memDi, scuDo;
	dqmMask_t cpuDqmN;
	logic cpuRdN, cpuCs3N, dramCeN, romCeN, sramCeN, smpcCeN, memWaitN, scuWaitN;
	smpcData_t smpcDo;
	logic bCs1N, bCs2N, bCssN, aCs2N;
	periphData_t vdp1Do, vdp2Do, scspDo, cdDo;
	logic ceR, ceF, smpcCe, mresN, cpuWaitN, dbgHook;
	cpuData_t cpuDi, memDo;
	cpuAddr_t memA;
	dqmMask_t memDqmN;
	logic memRdN, romCsN, sramCsN, ramlCsN, ramhCsN;
	periphData_t bDi, aDi;
	waitCnt_t dbgWaitCnt;

	// Reference state
	logic refMclk, refSmpc, refMres, refHook;
	smpcDivCnt_t refDiv;
	waitCnt_t refCnt;
	bit wrapSeen = 1'b0;

	integer seed;
	int valueErrors = 0;
	int otherErrors = 0;
	int hookStart;

	tbClockGen #(.PERIOD(CLK_PERIOD)) i_tbClockGen (.CLK(CLK));

	saturnBusGlue i_saturnBusGlue (.*);

	always @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			refMclk <= 1'b0;
			refDiv <= '0;
			refSmpc <= 1'b0;
			refMres <= 1'b0;
			refCnt <= '0;
			refHook <= 1'b0;
		end else begin
			if (ce && !dbgPause) begin
				refMclk <= ~refMclk;
			end
			refSmpc <= 1'b0;
			if (refSmpc) begin
				refMres <= 1'b1;
			end
			// Everything below runs on a rising phase only
			if (refMclk && !dbgPause) begin
				if (refDiv == DivLast) begin
					refDiv <= '0;
					refSmpc <= 1'b1;
				end else begin
					refDiv <= refDiv + 1'b1;
				end
				if (!cpuRdN || cpuDqmN != 4'hF) begin
					refCnt <= '0;
				end else begin
					refCnt <= refCnt + 1'b1;
					if (refCnt == '1) begin
						wrapSeen <= 1'b1;
					end
				end
				if (cpuA == HookAddr && !cpuRdN && !cpuCs3N) begin
					refHook <= 1'b1;
				end
			end
		end
	end

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			valueErrors++;
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic driveRandom(input int cycle);
		logic [31:0] r0, r1, r2, r3;
		r0 = $random(seed);
		r1 = $random(seed);
		r2 = $random(seed);
		r3 = $random(seed);
		ce = r0[1:0] != 2'd0;
		dbgPause = r0[4:2] == 3'd0;
		cpuRdN = r0[6:5] != 2'd0;
		cpuCs3N = r0[8:7] != 2'd0;
		dramCeN = r0[10:9] != 2'd0;
		romCeN = r0[12:11] != 2'd0;
		sramCeN = r0[14:13] != 2'd0;
		smpcCeN = r0[16:15] != 2'd0;
		memWaitN = r0[17];
		scuWaitN = r0[19:18] != 2'd0;
		bCs1N = r0[21:20] != 2'd0;
		bCs2N = r0[23:22] != 2'd0;
		bCssN = r0[25:24] != 2'd0;
		aCs2N = r0[26];
		cpuDqmN = (r0[28:27] == 2'd0) ? r1[31:28] : 4'hF;
		cpuA = r1[24:0];
		smpcDo = r1[31:24];
		memDi = r2;
		scuDo = r3;
		cpuDo = {r2[15:0], r3[31:16]};
		vdp1Do = r2[31:16];
		vdp2Do = r3[15:0];
		scspDo = r1[15:0];
		cdDo = r2[23:8];
		// Quiet bus long enough for the idle counter to wrap
		if (cycle >= 100 && cycle < 1500) begin
			cpuRdN = 1'b1;
			cpuDqmN = 4'hF;
		end
		if (cycle >= hookStart && cycle < hookStart + 40) begin
			cpuA = HookAddr;
			cpuRdN = 1'b0;
			cpuCs3N = 1'b0;
		end
	endtask

	task automatic checkOutputs();
		logic memSel;
		cpuData_t expDi;
		periphData_t expB;
		memSel = !cpuCs3N || !dramCeN || !romCeN || !sramCeN;
		if (memSel) begin
			expDi = memDi;
		end else if (!smpcCeN) begin
			expDi = {smpcDo, smpcDo, smpcDo, smpcDo};
		end else begin
			expDi = scuDo;
		end
		if (!bCs1N) begin
			expB = vdp1Do;
		end else if (!bCs2N) begin
			expB = vdp2Do;
		end else begin
			expB = !bCssN ? scspDo : '0;
		end
		checkValue("ceR", 32'(ceR), 32'(refMclk && !dbgPause));
		checkValue("ceF", 32'(ceF), 32'(!refMclk && !dbgPause));
		checkValue("smpcCe", 32'(smpcCe), 32'(refSmpc));
		checkValue("mresN", 32'(mresN), 32'(refMres));
		checkValue("dbgWaitCnt", 32'(dbgWaitCnt), 32'(refCnt));
		checkValue("dbgHook", 32'(dbgHook), 32'(refHook));
		checkValue("cpuDi", cpuDi, expDi);
		checkValue("cpuWaitN", 32'(cpuWaitN), 32'(scuWaitN && (memWaitN || !memSel)));
		checkValue("memA", 32'(memA), 32'(cpuA));
		checkValue("memDo", memDo, cpuDo);
		checkValue("memDqmN", 32'(memDqmN), 32'(cpuDqmN));
		checkValue("memRdN", 32'(memRdN), 32'(cpuRdN));
		checkValue("romCsN", 32'(romCsN), 32'(romCeN));
		checkValue("sramCsN", 32'(sramCsN), 32'(sramCeN));
		checkValue("ramlCsN", 32'(ramlCsN), 32'(dramCeN));
		checkValue("ramhCsN", 32'(ramhCsN), 32'(cpuCs3N));
		checkValue("bDi", 32'(bDi), 32'(expB));
		checkValue("aDi", 32'(aDi), 32'(!aCs2N ? cdDo : 16'h0000));
	endtask

	initial begin
		logic [31:0] r;
		seed = 32'ha40e_d908;
		RST_N = 1'b0;
		ce = 1'b0;
		dbgPause = 1'b0;
		cpuA = '0;
		cpuDo = '0;
		cpuDqmN = 4'hF;
		cpuRdN = 1'b1;
		cpuCs3N = 1'b1;
		dramCeN = 1'b1;
		romCeN = 1'b1;
		sramCeN = 1'b1;
		smpcCeN = 1'b1;
		memDi = '0;
		smpcDo = '0;
		scuDo = '0;
		memWaitN = 1'b1;
		scuWaitN = 1'b1;
		bCs1N = 1'b1;
		bCs2N = 1'b1;
		bCssN = 1'b1;
		vdp1Do = '0;
		vdp2Do = '0;
		scspDo = '0;
		aCs2N = 1'b1;
		cdDo = '0;
		r = $random(seed);
		hookStart = 1600 + int'(r[10:0]);
		repeat (RESET_CYCLES) @(posedge CLK);
		@(negedge CLK);
		RST_N = 1'b1;
		for (int cycle = 0; cycle < NUM_CYCLES; cycle++) begin
			@(negedge CLK);
			driveRandom(cycle);
			#1;
			checkOutputs();
		end
		if (!wrapSeen) begin
			otherErrors++;
			$display("The idle counter never wrapped during the run");
		end
		if (!refHook) begin
			otherErrors++;
			$display("No read ever reached the boot hook address");
		end
		if (!refMres) begin
			otherErrors++;
			$display("The master reset was never released");
		end
		$display("Summary: %0d value mismatches, %0d other errors", valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
		$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/saturnBusGlue_props.sv
`timescale 1ns/10ps
`default_nettype none

module saturnBusGlueProps (
	input logic CLK,
	input logic RST_N,
	input logic ceR,
	input logic ceF,
	input logic smpcCe,
	input logic mresN
);

	// Phases are mutually exclusive
	phaseExclusive: assert property (@(posedge CLK) disable iff (!RST_N) !(ceR && ceF))
		else $error("ceR and ceF are high in the same cycle");

	// SMPC strobe is a single-cycle pulse
	smpcSinglePulse: assert property (@(posedge CLK) disable iff (!RST_N) smpcCe |=> !smpcCe)
		else $error("smpcCe stayed high for two cycles");

	// Master reset release is final
	mresSticky: assert property (@(posedge CLK) disable iff (!RST_N) mresN |=> mresN)
		else $error("mresN fell after it was released");

endmodule

bind clockEnableGen saturnBusGlueProps i_props (
	.CLK(CLK),
	.RST_N(RST_N),
	.ceR(ceR),
	.ceF(clk.ceF),
	.smpcCe(smpcPulse),
	.mresN(mresN)
);

`default_nettype wire

// File: verification/tbClockGen.sv
`timescale 1ns/10ps
`default_nettype none

module tbClockGen #(
	parameter int PERIOD = 8
) (
	output logic CLK
);

	initial begin
		CLK = 1'b0;
		forever #(PERIOD / 2) CLK = ~CLK;
	end

endmodule

`default_nettype wire

// File: src/saturnBusGlue.sv
`timescale 1ns/10ps
`default_nettype none

module saturnBusGlue import saturnBusPkg::*, saturnTimingPkg::*; (
	input  logic CLK,
	input  logic RST_N,
	input  logic ce,
	input  logic dbgPause,

	// Master CPU bus
	input  cpuAddr_t cpuA,
	input  cpuData_t cpuDo,
	input  dqmMask_t cpuDqmN,
	input  logic cpuRdN,
	input  logic cpuCs3N,

	// DCC selects and read sources
	input  logic dramCeN,
	input  logic romCeN,
	input  logic sramCeN,
	input  logic smpcCeN,
	input  cpuData_t memDi,
	input  smpcData_t smpcDo,
	input  cpuData_t scuDo,
	input  logic memWaitN,
	input  logic scuWaitN,

	input  logic bCs1N,
	input  logic bCs2N,
	input  logic bCssN,
	input  periphData_t vdp1Do,
	input  periphData_t vdp2Do,
	input  periphData_t scspDo,
	input  logic aCs2N,
	input  periphData_t cdDo,

	output logic ceR,
	output logic ceF,
	output logic smpcCe,
	output logic mresN,

	output cpuData_t cpuDi,
	output logic cpuWaitN,

	// External memory port
	output cpuAddr_t memA,
	output cpuData_t memDo,
	output dqmMask_t memDqmN,
	output logic memRdN,
	output logic romCsN,
	output logic sramCsN,
	output logic ramlCsN,
	output logic ramhCsN,

	output periphData_t bDi,
	output periphData_t aDi,

	output waitCnt_t dbgWaitCnt,
	output logic dbgHook
);

	clockEnableIf clkIf();
	cpuBusIf cpuBus();

	assign cpuBus.addr = cpuA;
	assign cpuBus.rdN = cpuRdN;
	assign cpuBus.dqmN = cpuDqmN;
	assign cpuBus.cs3N = cpuCs3N;

	clockEnableGen i_clockEnableGen (
		.CLK(CLK),
		.RST_N(RST_N),
		.ce(ce),
		.dbgPause(dbgPause),
		.clk(clkIf.source),
		.mresN(mresN)
	);

	busReadRouter i_busReadRouter (
		.cpuBus(cpuBus.monitor),
		.dramCeN(dramCeN),
		.romCeN(romCeN),
		.sramCeN(sramCeN),
		.smpcCeN(smpcCeN),
		.memDi(memDi),
		.smpcDo(smpcDo),
		.scuDo(scuDo),
		.cpuDi(cpuDi),
		.memWaitN(memWaitN),
		.scuWaitN(scuWaitN),
		.cpuWaitN(cpuWaitN),
		.bCs1N(bCs1N),
		.bCs2N(bCs2N),
		.bCssN(bCssN),
		.vdp1Do(vdp1Do),
		.vdp2Do(vdp2Do),
		.scspDo(scspDo),
		.bDi(bDi),
		.aCs2N(aCs2N),
		.cdDo(cdDo),
		.aDi(aDi)
	);

	busActivityMonitor i_busActivityMonitor (
		.CLK(CLK),
		.RST_N(RST_N),
		.clk(clkIf.sink),
		.cpuBus(cpuBus.monitor),
		.dbgWaitCnt(dbgWaitCnt),
		.dbgHook(dbgHook)
	);

	assign ceR = clkIf.ceR;
	assign ceF = clkIf.ceF;
	assign smpcCe = clkIf.smpcCe;

	// Memory controller sees the CPU bus directly
	assign memA = cpuBus.addr;
	assign memDo = cpuDo;
	assign memDqmN = cpuBus.dqmN;
	assign memRdN = cpuBus.rdN;
	assign romCsN = romCeN;
	assign sramCsN = sramCeN;
	assign ramlCsN = dramCeN;
	assign ramhCsN = cpuBus.cs3N;

endmodule

`default_nettype wire

// File: src/busActivityMonitor.sv
`timescale 1ns/10ps
`default_nettype none

`include "saturn_config.svh"

module busActivityMonitor import saturnBusPkg::*, saturnTimingPkg::*; (
	input  logic CLK,
	input  logic RST_N,
	clockEnableIf.sink clk,
	cpuBusIf.monitor cpuBus,
	output waitCnt_t dbgWaitCnt,
	output logic dbgHook
);

	localparam cpuAddr_t HookAddr = `BOOT_HOOK_ADDR;

	logic busAccess;
	logic hookHit;

	// Any read or byte write counts as activity
	assign busAccess = ~cpuBus.rdN | ~(&cpuBus.dqmN);
	assign hookHit = (cpuBus.addr == HookAddr) & ~cpuBus.rdN & ~cpuBus.cs3N;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			dbgWaitCnt <= '0;
			dbgHook <= 1'b0;
		end else if (clk.ceR) begin
			if (busAccess) begin
				dbgWaitCnt <= '0;
			end else begin
				dbgWaitCnt <= dbgWaitCnt + 1'b1;
			end
			// Sticky until reset
			if (hookHit) begin
				dbgHook <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: src/busReadRouter.sv
`timescale 1ns/10ps
`default_nettype none

module busReadRouter import saturnBusPkg::*; (
	cpuBusIf.monitor cpuBus,

	// Chip selects from the DCC
	input  logic dramCeN,
	input  logic romCeN,
	input  logic sramCeN,
	input  logic smpcCeN,

	input  cpuData_t memDi,
	input  smpcData_t smpcDo,
	input  cpuData_t scuDo,
	output cpuData_t cpuDi,

	input  logic memWaitN,
	input  logic scuWaitN,
	output logic cpuWaitN,

	// B-bus
	input  logic bCs1N,
	input  logic bCs2N,
	input  logic bCssN,
	input  periphData_t vdp1Do,
	input  periphData_t vdp2Do,
	input  periphData_t scspDo,
	output periphData_t bDi,

	// A-bus, only the CD block answers
	input  logic aCs2N,
	input  periphData_t cdDo,
	output periphData_t aDi
);

	logic memSel;

	// High RAM, low RAM, BIOS ROM or backup RAM
	assign memSel = ~cpuBus.cs3N | ~dramCeN | ~romCeN | ~sramCeN;

	always_comb begin
		if (memSel) begin
			cpuDi = memDi;
		end else if (!smpcCeN) begin
			// SMPC byte shows up on every lane
			cpuDi = {4{smpcDo}};
		end else begin
			cpuDi = scuDo;
		end
	end

	// Memory wait only counts while memory is selected
	assign cpuWaitN = scuWaitN & (memWaitN | ~memSel);

	always_comb begin
		if (!bCs1N) begin
			bDi = vdp1Do;
		end else if (!bCs2N) begin
			bDi = vdp2Do;
		end else if (!bCssN) begin
			bDi = scspDo;
		end else begin
			bDi = '0;
		end
	end

	assign aDi = !aCs2N ? cdDo : '0;

endmodule

`default_nettype wire

// File: src/clockEnableGen.sv
`timescale 1ns/10ps
`default_nettype none

`include "saturn_config.svh"

module clockEnableGen import saturnTimingPkg::*; (
	input  logic CLK,
	input  logic RST_N,
	input  logic ce,
	input  logic dbgPause,
	clockEnableIf.source clk,
	output logic mresN
);

	localparam smpcDivCnt_t DivLast = smpcDivCnt_t'(`SMPC_DIV - 1);

	logic pause;
	logic mclk;
	logic ceR;
	smpcDivCnt_t smpcCnt;
	logic smpcPulse;

	// Only the debug pause can stop the clock here
	assign pause = dbgPause;

	// Master clock phase, frozen while paused
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			mclk <= 1'b0;
		end else if (ce && !pause) begin
			mclk <= ~mclk;
		end
	end

	assign ceR = mclk & ~pause;

	// SMPC runs at one seventh of the rising phase rate
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			smpcCnt <= '0;
			smpcPulse <= 1'b0;
		end else begin
			smpcPulse <= 1'b0;
			if (ceR) begin
				if (smpcCnt == DivLast) begin
					smpcCnt <= '0;
					smpcPulse <= 1'b1;
				end else begin
					smpcCnt <= smpcCnt + 1'b1;
				end
			end
		end
	end

	// Master reset held until the SMPC has seen its first clock
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			mresN <= 1'b0;
		end else if (smpcPulse) begin
			mresN <= 1'b1;
		end
	end

	assign clk.ceR = ceR;
	assign clk.ceF = ~mclk & ~pause;
	assign clk.smpcCe = smpcPulse;
	assign clk.pause = pause;

endmodule

`default_nettype wire

// File: src/saturnIfs.sv
`timescale 1ns/10ps
`default_nettype none

// Phase strobes shared by everything clocked off the master clock
interface clockEnableIf;
	logic ceR;
	logic ceF;
	logic smpcCe;
	logic pause;

	modport source (output ceR, output ceF, output smpcCe, output pause);
	modport sink (input ceR, input ceF, input smpcCe, input pause);
endinterface

// Master SH-2 side of the main bus
interface cpuBusIf import saturnBusPkg::*;;
	cpuAddr_t addr;
	logic rdN;
	dqmMask_t dqmN;
	logic cs3N;

	modport monitor (input addr, input rdN, input dqmN, input cs3N);
endinterface

`default_nettype wire

// File: src/saturnTimingPkg.sv
`default_nettype none

`include "saturn_config.svh"

package saturnTimingPkg;

	// Divider count for the slow-controller strobe
	typedef logic [2:0] smpcDivCnt_t;

	// Rising phases since the last bus access
	typedef logic [`WAIT_CNT_W-1:0] waitCnt_t;

endpackage

`default_nettype wire

// File: src/saturnBusPkg.sv
`default_nettype none

package saturnBusPkg;

	// Main CPU bus, as seen by SCU and DCC
	typedef logic [24:0] cpuAddr_t;
	typedef logic [31:0] cpuData_t;

	// Byte write strobes, active low, one per byte lane
	typedef logic [3:0] dqmMask_t;

	// B-bus (VDP1, VDP2, SCSP) and A-bus (CD block) share one width
	typedef logic [15:0] periphData_t;

	// SMPC register port is a single byte
	typedef logic [7:0] smpcData_t;

endpackage

`default_nettype wire

// File: include/saturn_config.svh
`ifndef SATURN_CONFIG_SVH
`define SATURN_CONFIG_SVH

// Slow-controller clock divider
// Rising phases between two SMPC strobes
`define SMPC_DIV 7

// Main-bus byte address watched by the activity monitor
// Boot code reads here once the BIOS hands over to the loader
`define BOOT_HOOK_ADDR 25'h0012B0

// Idle bus cycle counter
`define WAIT_CNT_W 8

`endif
